// ==== common/streamer_pkg.sv ====
// Shared definitions for the memory-to-stream source streamer.
// Holds the data widths, FIFO depths, the job configuration struct
// and the job state encoding. Modules import it inside their body and
// use scoped names for port types.

package streamer_pkg;

  // widths
  localparam int unsigned AddrWidth    = 32;  // byte address
  localparam int unsigned WordWidth    = 32;  // stream word
  localparam int unsigned MemDataWidth = WordWidth + 32;  // spare word for misaligned reads
  localparam int unsigned OffsetWidth  = 2;   // byte offset in a 32-bit word
  localparam int unsigned CntWidth     = 16;  // word, line and stride counts

  // queue sizes
  localparam int unsigned AddrFifoDepth   = 2;  // generator to request unit
  localparam int unsigned OffsetFifoDepth = 8;  // max loads in flight

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [WordWidth-1:0]    word_t;
  typedef logic [MemDataWidth-1:0] mem_data_t;
  typedef logic [OffsetWidth-1:0]  offset_t;
  typedef logic [CntWidth-1:0]     cnt_t;

  // job configuration held stable while a job runs
  typedef struct packed {
    addr_t base_addr;    // first byte address
    cnt_t  tot_len;      // words in the job
    cnt_t  line_len;     // words per line
    cnt_t  word_stride;  // bytes between words of a line
    cnt_t  line_stride;  // bytes between line starts
  } src_cfg_t;

  // job state of the memory source
  typedef enum logic [1:0] {
    SrcIdle,   // waiting for start
    SrcWork,   // generator still producing addresses
    SrcDrain   // all addresses out, waiting for the last words
  } src_state_e;

endpackage

// ==== verilog/stream_fifo.sv ====
// Synchronous circular-buffer FIFO with a type parameter for the payload.
// Push and pop use valid/ready; a pushed entry is visible at the output
// one cycle later. clear_i empties the FIFO in the next cycle.
// Used for byte addresses and for the byte offsets of loads in flight.

`timescale 1ns/1ns

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o,
  output logic     full_o
);

  typedef logic [$clog2(Depth)-1:0]   ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] usage_t;

  payload_t mem_q [Depth];  // storage
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  usage_t   usage_q;        // entries held
  logic     push_fire;
  logic     pop_fire;

  assign empty_o      = (usage_q == '0);
  assign full_o       = (usage_q == usage_t'(Depth));
  assign push_ready_o = ~full_o;
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_fire = push_valid_i & ~full_o;
  assign pop_fire  = pop_ready_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;  // drop everything held
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + ptr_t'(1);  // wrap
      end
      if (pop_fire) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      if (push_fire && !pop_fire) begin
        usage_q <= usage_q + usage_t'(1);
      end else if (pop_fire && !push_fire) begin
        usage_q <= usage_q - usage_t'(1);
      end
    end
  end

  // payload write
  always_ff @(posedge clk_i) begin
    if (push_fire && !clear_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== verilog/addr_gen.sv ====
// Two-dimensional address pattern generator of the source streamer.
// go_i loads the job from cfg_i; one byte address per accepted push
// follows, walking words of a line by word_stride and line starts by
// line_stride. gen_done_o rises after the last address is taken and
// stays high until clear_i.

`timescale 1ns/1ns

module addr_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   go_i,
  input  streamer_pkg::src_cfg_t cfg_i,
  output logic                   addr_valid_o,
  output streamer_pkg::addr_t    addr_o,
  input  logic                   addr_ready_i,
  output logic                   gen_done_o
);

  import streamer_pkg::*;

  logic  busy_q;       // addresses left to issue
  logic  done_q;       // last address accepted
  cnt_t  word_cnt_q;   // index of the current word in the job
  cnt_t  line_cnt_q;   // position of the current word in its line
  addr_t line_base_q;  // first address of the current line
  addr_t cur_addr_q;   // address on the output
  logic  accept;
  logic  last_word;
  logic  last_in_line;
  addr_t next_line_base;

  assign addr_valid_o = busy_q;
  assign addr_o       = cur_addr_q;
  assign gen_done_o   = done_q;

  assign accept         = busy_q & addr_ready_i;
  assign last_word      = (word_cnt_q == cfg_i.tot_len - cnt_t'(1));
  assign last_in_line   = (line_cnt_q == cfg_i.line_len - cnt_t'(1));
  assign next_line_base = line_base_q + addr_t'(cfg_i.line_stride);

  // control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (clear_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (go_i) begin
      busy_q     <= (cfg_i.tot_len != '0);
      done_q     <= (cfg_i.tot_len == '0);  // empty job ends at once
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (accept) begin
      if (last_word) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      word_cnt_q <= word_cnt_q + cnt_t'(1);
      line_cnt_q <= last_in_line ? '0 : line_cnt_q + cnt_t'(1);
    end
  end

  // address registers
  always_ff @(posedge clk_i) begin
    if (go_i) begin
      line_base_q <= cfg_i.base_addr;
      cur_addr_q  <= cfg_i.base_addr;
    end else if (accept) begin
      if (last_in_line) begin
        line_base_q <= next_line_base;  // jump to next line
        cur_addr_q  <= next_line_base;
      end else begin
        cur_addr_q <= cur_addr_q + addr_t'(cfg_i.word_stride);
      end
    end
  end

endmodule

// ==== source/mem_source.sv ====
// Memory side of the source streamer with the job FSM.
// Pops byte addresses, issues word-aligned loads on the 64-bit memory
// port and queues each load's byte offset. Responses go straight to the
// output stream, or through a hold register while the stream stalls,
// and are realigned to the queued offset. A word counter ends the job
// with a one-cycle done pulse. After clear_i, loads still in flight are
// drained from the memory port and dropped.

`timescale 1ns/1ns

module mem_source (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  streamer_pkg::src_cfg_t  cfg_i,
  output logic                    ready_start_o,
  output logic                    done_o,
  output logic                    gen_go_o,
  output logic                    gen_clear_o,
  input  logic                    gen_done_i,
  input  logic                    addr_valid_i,
  input  streamer_pkg::addr_t     addr_i,
  output logic                    addr_ready_o,
  input  logic                    addr_fifo_empty_i,
  output logic                    mem_req_o,
  output streamer_pkg::addr_t     mem_addr_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  streamer_pkg::mem_data_t mem_rdata_i,
  output logic                    mem_rready_o,
  output logic                    stream_valid_o,
  output streamer_pkg::word_t     stream_data_o,
  input  logic                    stream_ready_i
);

  import streamer_pkg::*;

  src_state_e state_q, state_d;
  logic       finish;         // last word delivered
  logic       gnt_fire;
  logic       rsp_fire;
  logic       stream_fire;
  logic       off_push_ready;
  logic       off_valid;
  offset_t    off_head;       // offset of the oldest load
  logic       hold_valid_q;
  mem_data_t  hold_data_q;
  mem_data_t  rsp_data;
  cnt_t       word_cnt_q;     // stream transfers in this job
  cnt_t       in_flight_q;    // granted loads without response
  cnt_t       in_flight_d;
  cnt_t       drop_q;         // responses to discard after clear
  logic       drop_active;

  // request side
  assign mem_req_o    = (state_q != SrcIdle) & addr_valid_i & stream_ready_i & off_push_ready;
  assign mem_addr_o   = {addr_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};  // word aligned
  assign gnt_fire     = mem_req_o & mem_gnt_i;
  assign addr_ready_o = gnt_fire;  // pop address on grant

  // byte offsets of loads in flight
  stream_fifo #(
    .payload_t ( offset_t        ),
    .Depth     ( OffsetFifoDepth )
  ) i_offset_fifo (
    .clk_i        ( clk_i                    ),
    .rst_ni       ( rst_ni                   ),
    .clear_i      ( clear_i                  ),
    .push_valid_i ( gnt_fire                 ),
    .push_data_i  ( addr_i[OffsetWidth-1:0]  ),
    .push_ready_o ( off_push_ready           ),
    .pop_valid_o  ( off_valid                ),
    .pop_data_o   ( off_head                 ),
    .pop_ready_i  ( stream_fire              ),
    .empty_o      (                          ),
    .full_o       (                          )
  );

  // response side
  assign drop_active    = (drop_q != '0);
  assign mem_rready_o   = stream_ready_i | drop_active;  // flush old loads after clear
  assign rsp_fire       = mem_rvalid_i & mem_rready_o;
  assign stream_valid_o = ~drop_active & off_valid & (mem_rvalid_i | hold_valid_q);
  assign stream_fire    = stream_valid_o & stream_ready_i;

  assign rsp_data      = hold_valid_q ? hold_data_q : mem_rdata_i;
  assign stream_data_o = rsp_data[{off_head, 3'b000} +: WordWidth];  // 4 bytes from offset

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i || stream_ready_i) begin
      hold_valid_q <= 1'b0;  // word leaves on ready
    end else if (mem_rvalid_i && !drop_active) begin
      hold_valid_q <= 1'b1;  // stalled response
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i && !stream_ready_i && !hold_valid_q && !drop_active) begin
      hold_data_q <= mem_rdata_i;  // capture once, then keep stable
    end
  end

  // loads in flight and drop count
  assign in_flight_d = in_flight_q + cnt_t'(gnt_fire) - cnt_t'(rsp_fire);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= '0;
      drop_q      <= '0;
    end else begin
      in_flight_q <= in_flight_d;
      if (clear_i) begin
        drop_q <= in_flight_d;  // everything outstanding is stale
      end else if (rsp_fire && drop_active) begin
        drop_q <= drop_q - cnt_t'(1);
      end
    end
  end

  // transfer counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
    end else if (clear_i || finish) begin
      word_cnt_q <= '0;
    end else if (stream_fire) begin
      word_cnt_q <= word_cnt_q + cnt_t'(1);
    end
  end

  // job FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SrcIdle;
    end else if (clear_i) begin
      state_q <= SrcIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    finish  = 1'b0;
    case (state_q)
      SrcIdle: begin
        if (start_i) begin
          state_d = SrcWork;
        end
      end
      SrcWork: begin
        if (gen_done_i) begin
          state_d = SrcDrain;  // no more addresses coming
        end
      end
      SrcDrain: begin
        if (addr_fifo_empty_i && (word_cnt_q == cfg_i.tot_len)) begin
          state_d = SrcIdle;
          finish  = 1'b1;
        end
      end
      default: begin
        state_d = SrcIdle;
      end
    endcase
  end

  assign ready_start_o = (state_q == SrcIdle);
  assign done_o        = finish;
  assign gen_go_o      = ready_start_o & start_i;
  assign gen_clear_o   = clear_i | finish;  // rearm generator for next job

endmodule

// ==== verilog/source_streamer_top.sv ====
// Top level of the memory-to-stream source streamer.
// Joins the address generator, the address FIFO and the memory source.
// Start a job with start_i while ready_start_o is high; cfg_i must stay
// stable until done_o.

`timescale 1ns/1ns

module source_streamer_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  streamer_pkg::src_cfg_t  cfg_i,
  output logic                    ready_start_o,
  output logic                    done_o,
  output logic                    mem_req_o,
  output streamer_pkg::addr_t     mem_addr_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  streamer_pkg::mem_data_t mem_rdata_i,
  output logic                    mem_rready_o,
  output logic                    stream_valid_o,
  output streamer_pkg::word_t     stream_data_o,
  input  logic                    stream_ready_i
);

  import streamer_pkg::*;

  logic  push_valid;  // generator to FIFO
  addr_t push_addr;
  logic  push_ready;
  logic  pop_valid;   // FIFO to memory source
  addr_t pop_addr;
  logic  pop_ready;
  logic  addr_fifo_empty;
  logic  gen_go;
  logic  gen_clear;
  logic  gen_done;

  addr_gen i_addr_gen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( gen_clear  ),
    .go_i         ( gen_go     ),
    .cfg_i        ( cfg_i      ),
    .addr_valid_o ( push_valid ),
    .addr_o       ( push_addr  ),
    .addr_ready_i ( push_ready ),
    .gen_done_o   ( gen_done   )
  );

  stream_fifo #(
    .payload_t ( addr_t        ),
    .Depth     ( AddrFifoDepth )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( push_valid      ),
    .push_data_i  ( push_addr       ),
    .push_ready_o ( push_ready      ),
    .pop_valid_o  ( pop_valid       ),
    .pop_data_o   ( pop_addr        ),
    .pop_ready_i  ( pop_ready       ),
    .empty_o      ( addr_fifo_empty ),
    .full_o       (                 )
  );

  mem_source i_mem_source (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .start_i           ( start_i         ),
    .cfg_i             ( cfg_i           ),
    .ready_start_o     ( ready_start_o   ),
    .done_o            ( done_o          ),
    .gen_go_o          ( gen_go          ),
    .gen_clear_o       ( gen_clear       ),
    .gen_done_i        ( gen_done        ),
    .addr_valid_i      ( pop_valid       ),
    .addr_i            ( pop_addr        ),
    .addr_ready_o      ( pop_ready       ),
    .addr_fifo_empty_i ( addr_fifo_empty ),
    .mem_req_o         ( mem_req_o       ),
    .mem_addr_o        ( mem_addr_o      ),
    .mem_gnt_i         ( mem_gnt_i       ),
    .mem_rvalid_i      ( mem_rvalid_i    ),
    .mem_rdata_i       ( mem_rdata_i     ),
    .mem_rready_o      ( mem_rready_o    ),
    .stream_valid_o    ( stream_valid_o  ),
    .stream_data_o     ( stream_data_o   ),
    .stream_ready_i    ( stream_ready_i  )
  );

endmodule

// ==== dv/source_streamer_sva.sv ====
// Protocol assertions for the source streamer, bound to its top level.
// Checks the memory request handshake, output stability under
// back-pressure and the done and ready flags.

`timescale 1ns/1ns

module source_streamer_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                clear_i,
  input logic                ready_start_o,
  input logic                done_o,
  input logic                mem_req_o,
  input streamer_pkg::addr_t mem_addr_o,
  input logic                mem_gnt_i,
  input logic                stream_valid_o,
  input streamer_pkg::word_t stream_data_o,
  input logic                stream_ready_i
);

  // ungranted request stays with its address unless the stream stalls
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_req_o && !mem_gnt_i |=> !stream_ready_i || (mem_req_o && $stable(mem_addr_o)))
    else $error("memory request dropped or address changed before grant");

  stream_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    stream_valid_o && !stream_ready_i |=> stream_valid_o && $stable(stream_data_o))
    else $error("stream word changed under back-pressure");

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done_o high for two cycles");

  idle_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ready_start_o && mem_req_o))
    else $error("memory request while idle");

endmodule

// ==== dv/tb_source_streamer.sv ====
// Testbench for the memory-to-stream source streamer.
// Runs jobs through the configuration port against a 64-bit memory model
// with random grant gaps and response latency. Stream back-pressure is
// random in the stress tests. Every streamed word is checked against a
// reference model of the address pattern and the memory image.

`timescale 1ns/1ns

module tb_source_streamer;

  import streamer_pkg::*;

  localparam int unsigned JobTimeout = 3000;  // cycles allowed per wait

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      clear_i;
  logic      start_i;
  src_cfg_t  cfg_i;
  logic      ready_start_o;
  logic      done_o;
  logic      mem_req_o;
  addr_t     mem_addr_o;
  logic      mem_gnt_i      = 1'b0;
  logic      mem_rvalid_i   = 1'b0;
  mem_data_t mem_rdata_i    = '0;
  logic      mem_rready_o;
  logic      stream_valid_o;
  word_t     stream_data_o;
  logic      stream_ready_i = 1'b0;

  logic        bp_on      = 1'b0;  // random stream stalls
  int unsigned gnt_pct    = 80;    // grant probability in percent
  src_cfg_t    exp_cfg    = '0;    // job the compare process checks against
  int          job_id     = 0;
  int          seen_job   = 0;
  int          got_cnt    = 0;     // words of the current job
  int          words_seen = 0;
  logic        done_due   = 1'b0;
  logic        ready_due  = 1'b0;
  int          err_cnt    = 0;
  int          tests_run  = 0;
  addr_t       pend_addr[$];       // granted loads in grant order
  longint      pend_due[$];
  longint      cyc        = 0;

  source_streamer_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .cfg_i          ( cfg_i          ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_rvalid_i   ( mem_rvalid_i   ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .mem_rready_o   ( mem_rready_o   ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .stream_ready_i ( stream_ready_i )
  );

  bind source_streamer_top source_streamer_sva i_sva (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .stream_ready_i ( stream_ready_i )
  );

  always #5 clk_i = ~clk_i;  // 10 ns period

  // memory image with one byte per address
  function automatic logic [7:0] img_byte(input addr_t a);
    return 8'(a * 7 + 3);
  endfunction

  function automatic mem_data_t mem_word(input addr_t a);
    mem_data_t w;
    int        i;
    for (i = 0; i < 8; i++) begin
      w[8*i +: 8] = img_byte(a + addr_t'(i));  // lowest byte first
    end
    return w;
  endfunction

  // expected word k of a job from the 2D pattern
  function automatic word_t exp_word(input src_cfg_t cfg, input int k);
    int unsigned line_idx;
    int unsigned pos;
    addr_t       a;
    word_t       w;
    int          i;
    line_idx = k / cfg.line_len;
    pos      = k % cfg.line_len;
    a = cfg.base_addr + line_idx * cfg.line_stride + pos * cfg.word_stride;
    for (i = 0; i < 4; i++) begin
      w[8*i +: 8] = img_byte(a + addr_t'(i));
    end
    return w;
  endfunction

  task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
    if (act_v !== exp_v) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("error at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic report_and_finish(input int extra_errs);
    $display("%0d tests, %0d words checked, %0d errors", tests_run, words_seen,
             err_cnt + extra_errs);
    if (err_cnt + extra_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic start_job(input src_cfg_t cfg);
    exp_cfg = cfg;
    job_id++;  // compare process restarts its word index
    cfg_i   <= cfg;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > JobTimeout) begin
        $display("timeout: no done_o pulse in %s", what);
        report_and_finish(1);
      end
    end while (done_o !== 1'b1);
  endtask

  task automatic wait_words(input int count);
    int n;
    int target;
    n      = 0;
    target = words_seen + count;
    while (words_seen < target) begin
      @(posedge clk_i);
      n++;
      if (n > JobTimeout) begin
        $display("timeout: fewer than %0d stream words arrived", count);
        report_and_finish(1);
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  // in-order memory model that holds each response until taken
  always @(posedge clk_i) begin
    cyc++;
    if (!rst_ni) begin
      pend_addr.delete();
      pend_due.delete();
      mem_gnt_i    <= 1'b0;
      mem_rvalid_i <= 1'b0;
    end else begin
      if (mem_rvalid_i && mem_rready_o) begin
        void'(pend_addr.pop_front());  // response consumed
        void'(pend_due.pop_front());
      end
      if (mem_req_o && mem_gnt_i) begin
        pend_addr.push_back(mem_addr_o);
        pend_due.push_back(cyc + longint'($urandom_range(1, 6)));
      end
      mem_gnt_i <= ($urandom_range(0, 99) < gnt_pct);
      if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= mem_word(pend_addr[0]);
      end else begin
        mem_rvalid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    stream_ready_i <= bp_on ? ($urandom_range(0, 99) >= 40) : 1'b1;
  end

  // compare process
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (job_id != seen_job) begin
        seen_job = job_id;
        got_cnt  = 0;
      end
      check_bit("done_o", done_due, done_o);
      if (ready_due) begin
        check_bit("ready_start_o", 1'b1, ready_start_o);  // idle after done or clear
      end
      ready_due = done_o | clear_i;
      done_due  = 1'b0;
      if (stream_valid_o && stream_ready_i) begin
        if (got_cnt >= int'(exp_cfg.tot_len)) begin
          $display("unexpected stream word beyond the end of the job at %0t ns", $time);
          err_cnt++;
        end else begin
          check_word("stream_data_o", exp_word(exp_cfg, got_cnt), stream_data_o);
        end
        got_cnt++;
        words_seen++;
        done_due = (got_cnt == int'(exp_cfg.tot_len)) && !clear_i;
      end
    end
  end

  initial begin
    int err_before;
    int off;
    void'($urandom(96193));  // single seed for the run
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    start_i  = 1'b0;
    cfg_i    = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);

    err_before = err_cnt;
    check_bit("ready_start_o", 1'b1, ready_start_o);  // idle out of reset
    check_bit("mem_req_o", 1'b0, mem_req_o);
    check_bit("stream_valid_o", 1'b0, stream_valid_o);
    end_test("0 reset values", err_before);

    err_before = err_cnt;
    start_job('{32'h0000_0100, 16'd16, 16'd16, 16'd4, 16'd64});
    wait_done("aligned linear job");
    end_test("1 aligned linear", err_before);
    repeat (2) @(posedge clk_i);

    for (off = 1; off <= 3; off++) begin
      err_before = err_cnt;
      start_job('{addr_t'(32'h0000_0200 + off), 16'd9, 16'd9, 16'd4, 16'd36});
      wait_done("misaligned job");
      end_test($sformatf("2 misaligned offset %0d", off), err_before);
      repeat (2) @(posedge clk_i);
    end

    err_before = err_cnt;
    start_job('{32'h0000_0400, 16'd12, 16'd3, 16'd8, 16'd40});
    wait_done("2D job");
    end_test("3 two-dimensional", err_before);
    repeat (2) @(posedge clk_i);

    bp_on   = 1'b1;  // stalls and grant gaps from here on
    gnt_pct = 50;
    err_before = err_cnt;
    start_job('{32'h0000_1003, 16'd40, 16'd5, 16'd12, 16'd100});
    wait_done("back-pressure job");
    end_test("4 back-pressure", err_before);
    repeat (2) @(posedge clk_i);

    err_before = err_cnt;
    start_job('{32'h0000_2000, 16'd6, 16'd6, 16'd4, 16'd24});
    wait_done("first of two jobs");
    start_job('{32'h0000_2102, 16'd10, 16'd4, 16'd4, 16'd24});  // right after done
    wait_done("second of two jobs");
    end_test("5 back-to-back jobs", err_before);
    repeat (2) @(posedge clk_i);

    err_before = err_cnt;
    start_job('{32'h0000_3001, 16'd30, 16'd7, 16'd4, 16'd64});
    wait_words(6);
    clear_i <= 1'b1;  // abort with loads in flight
    @(posedge clk_i);
    clear_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    start_job('{32'h0000_3402, 16'd12, 16'd4, 16'd8, 16'd48});
    wait_done("job after clear");
    end_test("6 clear mid job", err_before);
    repeat (4) @(posedge clk_i);

    report_and_finish(0);
  end

endmodule

// ==== source_streamer_top.f ====
common/streamer_pkg.sv
verilog/stream_fifo.sv
verilog/addr_gen.sv
source/mem_source.sv
verilog/source_streamer_top.sv
dv/source_streamer_sva.sv
dv/tb_source_streamer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the source streamer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_source_streamer \
  -f source_streamer_top.f \
  -o tb_source_streamer

out=$(./obj_dir/tb_source_streamer 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q -F "Done: no errors"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
